/* include/pdp8_settings.svh */
// Widths fixed by the PDP-8 architecture; the octal IOT codes assume a 12-bit word
`ifndef PDP8_SETTINGS_SVH
`define PDP8_SETTINGS_SVH

// Machine word
`define PDP8_WORD_W 12

// One 4K memory field
`define PDP8_FIELD_W 3

// Save register {uf, inst_field, data_field}
`define PDP8_SAVE_W 7

`endif

/* design/pdp8_cpu_pkg.sv */
// Major-state and opcode types; state codes carry no meaning beyond their names
package pdp8_cpu_pkg;

    typedef enum logic [4:0] {
        IDLE = 5'd0,
        F0   = 5'd1,   // Fetch
        F1   = 5'd2,
        F2   = 5'd3,
        F3   = 5'd4,
        D0   = 5'd5,   // Defer
        D1   = 5'd6,
        D2   = 5'd7,
        D3   = 5'd8,
        E0   = 5'd9,   // Execute
        E1   = 5'd10,
        E2   = 5'd11,
        E3   = 5'd12,
        H0   = 5'd13,  // Console
        H1   = 5'd14,
        H2   = 5'd15,
        H3   = 5'd16
    } major_state_t;

    // Instruction bits 0 to 2
    typedef enum logic [2:0] {
        AND = 3'o0,
        TAD = 3'o1,
        ISZ = 3'o2,
        DCA = 3'o3,
        JMS = 3'o4,
        JMP = 3'o5,
        IOT = 3'o6,
        OPR = 3'o7
    } opcode_t;

endpackage

/* design/pdp8_mex_pkg.sv */
// Memory-extension types; only the fixed IOT words are listed, CDF and CIF carry a field
`include "pdp8_settings.svh"

package pdp8_mex_pkg;

    typedef struct packed {
        logic                     uf;          // User flag
        logic                     ui;          // User interrupt
        logic [`PDP8_FIELD_W-1:0] inst_field;
        logic [`PDP8_FIELD_W-1:0] data_field;
        logic                     int_ena;
        logic                     int_inh;     // Held until the next JMP or JMS
        logic [1:0]               pad;
    } mex_regs_t;

    typedef enum logic [`PDP8_WORD_W-1:0] {
        SKON = 12'o6000,
        ION  = 12'o6001,
        IOF  = 12'o6002,
        SRQ  = 12'o6003,
        GTF  = 12'o6004,
        RTF  = 12'o6005,
        SGT  = 12'o6006,
        CAF  = 12'o6007,
        CUI  = 12'o6204,
        RDF  = 12'o6214,
        RIF  = 12'o6224,
        RIB  = 12'o6234,
        RMF  = 12'o6244,
        SINT = 12'o6254,
        CUF  = 12'o6264,
        SUF  = 12'o6274
    } mex_iot_t;

endpackage

/* design/major_state_seq.sv */
// Strobes are accepted only in IDLE; each state lasts one clock and skip holds until the next F2
`timescale 1ns/10ps
`include "pdp8_settings.svh"

module major_state_seq
    import pdp8_cpu_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_stb,
    input  logic                    load_addr_stb,
    input  logic                    clear_stb,
    input  logic [`PDP8_WORD_W-1:0] instr,
    input  logic                    irq,
    input  logic                    int_ena,
    input  logic                    mskip,
    output major_state_t            state,
    output logic                    int_in_prog,
    output logic                    extd_addrd,
    output logic                    clear,
    output logic                    skip,
    output logic                    done
);

    opcode_t opcode;
    logic    indirect;
    logic    mem_ref;
    logic    clr_op;
    logic    at_end;
    logic    int_take;

    assign opcode   = opcode_t'(instr[11:9]);
    assign indirect = instr[8];
    assign mem_ref  = (opcode != IOT) && (opcode != OPR);
    assign int_take = int_ena && irq && !int_in_prog;  // Never nests
    assign clear    = clr_op && (state == H2);

    // Last state of the instruction itself
    always_comb
    begin
        case (state)
            F3:      at_end = !mem_ref || ((opcode == JMP) && !indirect);
            D3:      at_end = (opcode == JMP);
            E3:      at_end = 1'b1;
            default: at_end = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= IDLE;
            int_in_prog <= 1'b0;
            extd_addrd  <= 1'b0;
            clr_op      <= 1'b0;
            skip        <= 1'b0;
            done        <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (at_end)
            begin
                if (int_take)
                begin
                    state       <= E0;  // Interrupt cycle
                    int_in_prog <= 1'b1;
                end
                else
                begin
                    state       <= IDLE;
                    int_in_prog <= 1'b0;
                    done        <= 1'b1;
                end
            end
            else
            begin
                case (state)
                    IDLE:
                        if (instr_stb)
                            state <= F0;
                        else if (load_addr_stb)
                        begin
                            state      <= H0;
                            extd_addrd <= 1'b1;
                        end
                        else if (clear_stb)
                        begin
                            state  <= H0;
                            clr_op <= 1'b1;
                        end
                    F0: state <= F1;
                    F1: state <= F2;
                    F2:
                    begin
                        state <= F3;
                        skip  <= mskip;  // Valid from F1 edge
                    end
                    F3: state <= indirect ? D0 : E0;
                    D0: state <= D1;
                    D1: state <= D2;
                    D2: state <= D3;
                    D3: state <= E0;
                    E0: state <= E1;
                    E1: state <= E2;
                    E2: state <= E3;
                    H0: state <= H1;
                    H1: state <= H2;
                    H2: state <= H3;
                    H3:
                    begin
                        state      <= IDLE;
                        extd_addrd <= 1'b0;
                        clr_op     <= 1'b0;
                        done       <= 1'b1;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

endmodule

/* design/mem_ext.sv */
// Vectors are [11:0] with PDP-8 bit 0 at index 11; peripheral IOTs and memory itself are not modelled
`timescale 1ns/10ps
`include "pdp8_settings.svh"

module mem_ext
    import pdp8_cpu_pkg::*, pdp8_mex_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`PDP8_WORD_W-1:0] instr,
    input  logic [`PDP8_WORD_W-1:0] mdout,
    input  logic [`PDP8_WORD_W-1:0] sr,
    input  logic [`PDP8_WORD_W-1:0] ac,
    input  major_state_t            state,
    input  logic                    clear,
    input  logic                    extd_addrd,
    input  logic                    gtf,
    input  logic                    int_in_prog,
    input  logic                    irq,
    output mex_regs_t               regs,
    output logic                    mskip,
    output logic [`PDP8_WORD_W-1:0] me_bus
);

    logic [`PDP8_FIELD_W-1:0] ib;       // Instruction buffer
    logic                     ub;       // User buffer
    logic [`PDP8_SAVE_W-1:0]  savereg;
    logic                     int_delay;
    opcode_t                  opcode;
    logic                     indirect;
    logic                     priv_opr;
    logic                     user_trap;
    logic                     field_xfer;

    assign opcode   = opcode_t'(instr[11:9]);
    assign indirect = instr[8];

    // Group 2 operate with HLT or OSR
    assign priv_opr = (instr[11:8] == 4'b1111) && !instr[0] && (instr[1] || instr[2]);

    assign user_trap = regs.uf && (((opcode == IOT) && (instr != SGT)) || priv_opr);

    // IB and UB take effect on the jump that follows CIF or SUF
    assign field_xfer = regs.int_inh &&
        (((state == F2) && (opcode == JMP) && !indirect) ||
         ((state == D2) && (opcode == JMP) && indirect) ||
         ((state == E2) && (opcode == JMS) && !int_in_prog));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            regs      <= '0;
            ib        <= '0;
            ub        <= 1'b0;
            savereg   <= '0;
            int_delay <= 1'b0;
            mskip     <= 1'b0;
            me_bus    <= '0;
        end
        else
        begin
            case (state)
                F1:
                    case (instr)
                        SRQ:     mskip <= !regs.uf && irq;
                        SGT:     mskip <= gtf;  // Either mode
                        SKON:    mskip <= !regs.uf && regs.int_ena;
                        SINT:    mskip <= !regs.uf && regs.ui;
                        default: mskip <= 1'b0;
                    endcase
                F2:
                begin
                    if (!regs.uf)
                    begin
                        case (instr)
                            GTF:
                                me_bus <= {mdout[11], gtf, irq, regs.int_inh,
                                           regs.int_ena | int_delay, savereg};
                            CUI:     regs.ui <= 1'b0;
                            RDF:     me_bus <= ac | {6'o00, regs.data_field, 3'o0};
                            RIF:     me_bus <= ac | {6'o00, regs.inst_field, 3'o0};
                            RIB:     me_bus <= ac | {5'b00000, savereg};
                            default: ;
                        endcase
                    end
                    if (user_trap)
                        regs.ui <= 1'b1;
                    if (int_delay)
                    begin
                        regs.int_ena <= 1'b1;
                        int_delay    <= 1'b0;
                    end
                end
                F3:
                begin
                    if (!regs.uf)
                    begin
                        casez (instr)
                            SKON, IOF:
                            begin
                                regs.int_ena <= 1'b0;
                                int_delay    <= 1'b0;
                            end
                            ION: int_delay <= 1'b1;  // Enabled at next F2
                            RTF:
                            begin
                                {ub, ib, regs.data_field} <= ac[6:0];
                                int_delay    <= 1'b1;
                                regs.int_inh <= 1'b1;
                            end
                            CAF:
                            begin
                                regs.int_ena <= 1'b0;
                                int_delay    <= 1'b0;
                                regs.uf      <= 1'b0;
                                regs.ui      <= 1'b0;
                                ub           <= 1'b0;
                            end
                            12'o62?1: regs.data_field <= instr[5:3];  // CDF
                            12'o62?2:
                            begin
                                ib           <= instr[5:3];  // CIF
                                regs.int_inh <= 1'b1;
                            end
                            12'o62?3:
                            begin
                                ib              <= instr[5:3];
                                regs.data_field <= instr[5:3];
                                regs.int_inh    <= 1'b1;
                            end
                            RMF:
                            begin
                                {ub, ib, regs.data_field} <= savereg;
                                regs.int_inh <= 1'b1;
                            end
                            CUF: ub <= 1'b0;
                            SUF:
                            begin
                                ub           <= 1'b1;
                                regs.int_inh <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    mskip <= 1'b0;
                end
                E0:
                    if (int_in_prog)
                    begin
                        savereg         <= {regs.uf, regs.inst_field, regs.data_field};
                        regs.inst_field <= '0;  // Service routine runs in field 0
                        regs.data_field <= '0;
                        ib              <= '0;
                        regs.uf         <= 1'b0;
                        ub              <= 1'b0;
                        regs.int_ena    <= 1'b0;
                        int_delay       <= 1'b0;
                    end
                H1:
                    if (extd_addrd)
                    begin
                        regs.inst_field <= sr[5:3];
                        ib              <= sr[5:3];
                        regs.data_field <= sr[2:0];
                        regs.uf         <= 1'b0;
                        ub              <= 1'b0;
                    end
                H2:
                    if (clear)
                    begin
                        regs.inst_field <= '0;
                        regs.data_field <= '0;
                        ib              <= '0;
                        savereg         <= '0;
                        regs.uf         <= 1'b0;
                        regs.ui         <= 1'b0;
                        ub              <= 1'b0;
                        regs.int_ena    <= 1'b0;
                        regs.int_inh    <= 1'b0;
                        int_delay       <= 1'b0;
                    end
                default: ;
            endcase

            if (field_xfer)
            begin
                regs.inst_field <= ib;
                regs.uf         <= ub;
                regs.int_inh    <= 1'b0;
            end
        end
    end

endmodule

/* design/mem_ext_top.sv */
// The instruction register loads only while the sequencer idles; memory and the AC path are external levels
`timescale 1ns/10ps
`include "pdp8_settings.svh"

module mem_ext_top
    import pdp8_cpu_pkg::*, pdp8_mex_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_stb,
    input  logic [`PDP8_WORD_W-1:0] instr,
    input  logic                    load_addr_stb,
    input  logic                    clear_stb,
    input  logic [`PDP8_WORD_W-1:0] ac,
    input  logic [`PDP8_WORD_W-1:0] sr,
    input  logic [`PDP8_WORD_W-1:0] mdout,
    input  logic                    irq,
    input  logic                    gtf,
    output mex_regs_t               regs,
    output logic [`PDP8_WORD_W-1:0] me_bus,
    output logic                    skip,
    output logic                    done
);

    logic [`PDP8_WORD_W-1:0] ir;
    major_state_t            state;
    logic                    int_in_prog;
    logic                    extd_addrd;
    logic                    clear;
    logic                    mskip;

    always_ff @(posedge clk)
    begin
        if (instr_stb && (state == IDLE))
            ir <= instr;
    end

    major_state_seq u_seq (
        .clk           (clk),
        .rst           (rst),
        .instr_stb     (instr_stb),
        .load_addr_stb (load_addr_stb),
        .clear_stb     (clear_stb),
        .instr         (ir),
        .irq           (irq),
        .int_ena       (regs.int_ena),
        .mskip         (mskip),
        .state         (state),
        .int_in_prog   (int_in_prog),
        .extd_addrd    (extd_addrd),
        .clear         (clear),
        .skip          (skip),
        .done          (done)
    );

    mem_ext u_mex (
        .clk         (clk),
        .rst         (rst),
        .instr       (ir),
        .mdout       (mdout),
        .sr          (sr),
        .ac          (ac),
        .state       (state),
        .clear       (clear),
        .extd_addrd  (extd_addrd),
        .gtf         (gtf),
        .int_in_prog (int_in_prog),
        .irq         (irq),
        .regs        (regs),
        .mskip       (mskip),
        .me_bus      (me_bus)
    );

endmodule

/* dv/mem_ext_properties.sv */
// Bound to every mem_ext_top instance; checks are held off while rst is high
`timescale 1ns/10ps
`include "pdp8_settings.svh"

module mem_ext_properties
    import pdp8_cpu_pkg::*, pdp8_mex_pkg::*;
(
    input logic                    clk,
    input logic                    rst,
    input major_state_t            state,
    input logic                    done,
    input mex_regs_t               regs,
    input logic [`PDP8_WORD_W-1:0] ir
);

    state_steps: assert property (@(posedge clk) disable iff (rst)
        (state != IDLE) |=> (state != $past(state)))
        else $error("Major state held for more than one clock");

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done stayed high for more than one clock");

    // Enable waits for the following instruction
    ion_delay: assert property (@(posedge clk) disable iff (rst)
        ((state == F3) && (ir == ION)) |=> !$rose(regs.int_ena))
        else $error("int_ena rose in the same instruction as ION");

    inh_release: assert property (@(posedge clk) disable iff (rst)
        (((state == F2) || (state == D2) || (state == E2)) &&
         ((ir[11:9] == JMP) || (ir[11:9] == JMS)))
        |=> ((regs.inst_field == $past(regs.inst_field)) || !regs.int_inh))
        else $error("inst_field changed on a jump while int_inh stayed set");

endmodule

bind mem_ext_top mem_ext_properties u_props (
    .clk   (clk),
    .rst   (rst),
    .state (state),
    .done  (done),
    .regs  (regs),
    .ir    (ir)
);

/* dv/mem_ext_tb.sv */
// Run from the project root so dv/mem_ext_golden.txt is found; mdout is held at zero throughout
`timescale 1ns/10ps
`include "pdp8_settings.svh"

module mem_ext_tb
    import pdp8_mex_pkg::*;
();

    typedef struct packed {
        logic [7:0]              kind;      // I, L or C
        logic [`PDP8_WORD_W-1:0] instr;
        logic [`PDP8_WORD_W-1:0] ac;
        logic [`PDP8_WORD_W-1:0] sr;
        logic                    irq;
        logic                    gtf;
        mex_regs_t               exp_regs;
        logic [`PDP8_WORD_W-1:0] exp_bus;
        logic                    exp_skip;
    } vector_t;

    logic                    clk;
    logic                    rst;
    logic                    instr_stb;
    logic [`PDP8_WORD_W-1:0] instr;
    logic                    load_addr_stb;
    logic                    clear_stb;
    logic [`PDP8_WORD_W-1:0] ac;
    logic [`PDP8_WORD_W-1:0] sr;
    logic [`PDP8_WORD_W-1:0] mdout;
    logic                    irq;
    logic                    gtf;
    mex_regs_t               regs;
    logic [`PDP8_WORD_W-1:0] me_bus;
    logic                    skip;
    logic                    done;

    vector_t     vecs[$];
    logic [31:0] lfsr;
    logic        loaded;

    mem_ext_top uut (
        .clk           (clk),
        .rst           (rst),
        .instr_stb     (instr_stb),
        .instr         (instr),
        .load_addr_stb (load_addr_stb),
        .clear_stb     (clear_stb),
        .ac            (ac),
        .sr            (sr),
        .mdout         (mdout),
        .irq           (irq),
        .gtf           (gtf),
        .regs          (regs),
        .me_bus        (me_bus),
        .skip          (skip),
        .done          (done)
    );

    initial
        clk = 1'b0;

    always #4 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic load_vectors();
        int                      fd;
        int                      n;
        string                   line;
        vector_t                 v;
        logic [7:0]              kind;
        logic [`PDP8_WORD_W-1:0] f_instr;
        logic [`PDP8_WORD_W-1:0] f_ac;
        logic [`PDP8_WORD_W-1:0] f_sr;
        logic [`PDP8_WORD_W-1:0] f_regs;
        logic [`PDP8_WORD_W-1:0] f_bus;
        logic                    f_irq;
        logic                    f_gtf;
        logic                    f_skip;
        fd = $fopen("dv/mem_ext_golden.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the vector file dv/mem_ext_golden.txt");
            $display("Result: FAILED");
            $fatal(1, "Missing vector file");
        end
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if ((n > 1) && (line[0] != "#"))
            begin
                n = $sscanf(line, "%c %o %o %o %d %d %h %o %d", kind, f_instr, f_ac, f_sr,
                            f_irq, f_gtf, f_regs, f_bus, f_skip);
                if (n != 9)
                begin
                    $display("Vector line has %0d of 9 fields: %s", n, line);
                    $display("Result: FAILED");
                    $fatal(1, "Bad vector line");
                end
                v.kind     = kind;
                v.instr    = f_instr;
                v.ac       = f_ac;
                v.sr       = f_sr;
                v.irq      = f_irq;
                v.gtf      = f_gtf;
                v.exp_regs = f_regs;
                v.exp_bus  = f_bus;
                v.exp_skip = f_skip;
                vecs.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    // One strobe, then wait for done
    task automatic run_vector(input vector_t v);
        @(posedge clk);
        #1;
        instr = v.instr;
        ac    = v.ac;
        sr    = v.sr;
        irq   = v.irq;
        gtf   = v.gtf;
        case (v.kind)
            "L":     load_addr_stb = 1'b1;
            "C":     clear_stb = 1'b1;
            default: instr_stb = 1'b1;
        endcase
        @(posedge clk);
        #1;
        instr_stb     = 1'b0;
        load_addr_stb = 1'b0;
        clear_stb     = 1'b0;
        while (!done)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_value(input logic [11:0] got, input logic [11:0] exp,
                               input string what);
        if (got !== exp)
        begin
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    initial
    begin
        int   idx;
        logic b0;
        logic b1;
        rst           = 1'b1;
        instr_stb     = 1'b0;
        instr         = '0;
        load_addr_stb = 1'b0;
        clear_stb     = 1'b0;
        ac            = '0;
        sr            = '0;
        mdout         = '0;
        irq           = 1'b0;
        gtf           = 1'b0;
        lfsr          = 32'h154a1810;
        loaded        = 1'b0;
        load_vectors();
        if (vecs.size() == 0)
        begin
            $display("The vector file holds no vectors");
            $display("Result: FAILED");
            $fatal(1, "Empty vector file");
        end
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (idx = 0; idx < vecs.size(); idx++)
        begin
            run_vector(vecs[idx]);
            check_value(regs, vecs[idx].exp_regs, $sformatf("vector %0d regs", idx));
            check_value(me_bus, vecs[idx].exp_bus, $sformatf("vector %0d me_bus", idx));
            check_value({11'b0, skip}, {11'b0, vecs[idx].exp_skip},
                        $sformatf("vector %0d skip", idx));
            b0   = lfsr[0];  // Idle gap of 0 to 3 clocks
            lfsr = lfsr_next(lfsr);
            b1   = lfsr[0];
            lfsr = lfsr_next(lfsr);
            repeat ({b1, b0}) @(posedge clk);
        end
        $display("Result: PASSED");
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (loaded);
        repeat (vecs.size() * 20 + 100) @(posedge clk);
        $display("Timeout: the DUT did not finish all vectors in time");
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* dv/mem_ext_golden.txt */
# kind(I instr, L load, C clear) instr ac sr irq gtf | expected regs me_bus skip
# instr, ac, sr and me_bus in octal; regs in hex as {uf,ui,if[3],df[3],ena,inh,pad[2]}
I 7000 0000 0000 0 0 000 0000 0
L 0000 0000 0053 0 0 2b0 0000 0
I 6211 0000 0000 0 0 290 0000 0
I 6222 0000 0000 0 0 294 0000 0
I 6214 0007 0000 0 0 294 0017 0
I 6224 1000 0000 0 0 294 1050 0
I 5200 0000 0000 0 0 110 1050 0
I 6203 0000 0000 0 0 104 1050 0
I 4300 0000 0000 0 0 000 1050 0
I 6001 0000 0000 0 0 000 1050 0
I 7000 0000 0000 0 0 008 1050 0
I 6000 0000 0000 0 0 000 1050 1
I 6001 0000 0000 0 0 000 1050 0
I 6007 0000 0000 0 0 000 1050 0
I 6001 0000 0000 0 0 000 1050 0
I 6002 0000 0000 0 0 000 1050 0
I 6233 0000 0000 0 0 034 1050 0
I 6001 0000 0000 0 0 034 1050 0
I 5200 0000 0000 1 0 000 1050 0
I 6234 0000 0000 0 0 000 0033 0
I 6004 0000 0000 1 1 000 3033 0
I 6003 0000 0000 1 0 000 3033 1
I 6006 0000 0000 0 1 000 3033 1
I 6006 0000 0000 0 0 000 3033 0
I 6274 0000 0000 0 0 004 3033 0
I 6264 0000 0000 0 0 004 3033 0
I 5600 0000 0000 0 0 000 3033 0
I 6001 0000 0000 0 0 000 3033 0
I 6251 0000 0000 0 0 058 3033 0
I 6274 0000 0000 0 0 05c 3033 0
I 5200 0000 0000 0 0 858 3033 0
I 7402 0000 0000 0 0 c58 3033 0
I 6211 0000 0000 0 0 c58 3033 0
I 6254 0000 0000 0 0 c58 3033 0
I 6006 0000 0000 0 1 c58 3033 1
I 7000 0000 0000 1 0 400 3033 0
I 6254 0000 0000 0 0 400 3033 1
I 6204 0000 0000 0 0 000 3033 0
I 6234 0000 0000 0 0 000 0105 0
I 6222 0000 0000 0 0 004 0105 0
C 0000 0000 0000 0 0 000 0105 0
I 6234 0000 0000 0 0 000 0000 0

/* flist.f */
+incdir+include
design/pdp8_cpu_pkg.sv
design/pdp8_mex_pkg.sv
design/major_state_seq.sv
design/mem_ext.sv
design/mem_ext_top.sv
dv/mem_ext_properties.sv
dv/mem_ext_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module mem_ext_tb -f flist.f

out=$(./obj_dir/Vmem_ext_tb 2>&1) || true
echo "$out"
echo "$out" | grep -q "^Result: PASSED$"
